//--- design/atomic_alu.sv
// combinational alu for tl-ul atomics on one bus word
// arithmetic: signed and unsigned min/max, add
// logical: xor, or, and, swap

`timescale 1ns/100ps
`include "tlul_defs.svh"

module atomic_alu import tlul_pkg::*; (
  // 1: ArithmeticData, 0: LogicalData
  input  logic              arith_i,
  // a_param of the request
  input  logic [2:0]        fn_i,
  // word currently stored in the sram
  input  logic [`TL_DW-1:0] mem_i,
  // word carried by the request
  input  logic [`TL_DW-1:0] op_i,
  output logic [`TL_DW-1:0] result_o
);

  logic slt, ult;

  // op_i below mem_i, both ways
  assign slt = $signed(op_i) < $signed(mem_i);
  assign ult = op_i < mem_i;

  always_comb begin
    // unknown function codes leave the word as it was
    result_o = mem_i;
    if (arith_i) begin
      case (arith_fn_e'(fn_i))
        AMin:    result_o = slt ? op_i : mem_i;
        AMax:    result_o = slt ? mem_i : op_i;
        AMinu:   result_o = ult ? op_i : mem_i;
        AMaxu:   result_o = ult ? mem_i : op_i;
        // carry out is dropped
        AAdd:    result_o = op_i + mem_i;
        default: result_o = mem_i;
      endcase
    end else begin
      case (logic_fn_e'(fn_i))
        LXor:    result_o = op_i ^ mem_i;
        LOr:     result_o = op_i | mem_i;
        LAnd:    result_o = op_i & mem_i;
        // swap stores the request word
        LSwap:   result_o = op_i;
        default: result_o = mem_i;
      endcase
    end
  end

endmodule

//--- design/fifo_sync.sv
// synchronous register-array fifo with fill level output
// push and pop in the same cycle are taken even when full

`timescale 1ns/100ps

module fifo_sync #(
  parameter int Width = 8,
  parameter int Depth = 2
) (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       wvalid_i,
  output logic                       wready_o,
  input  logic [Width-1:0]           wdata_i,
  output logic                       rvalid_o,
  input  logic                       rready_i,
  output logic [Width-1:0]           rdata_o,
  output logic [$clog2(Depth+1)-1:0] depth_o
);

  localparam int PtrW = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int CntW = $clog2(Depth + 1);

  logic [Width-1:0] mem_q [Depth];
  logic [PtrW-1:0]  wptr_q, rptr_q;
  logic [CntW-1:0]  cnt_q;
  logic             push, pop;

  // a full fifo still takes a word when the head leaves
  assign rvalid_o = (cnt_q != '0);
  assign wready_o = (cnt_q < CntW'(Depth)) || rready_i;
  assign push     = wvalid_i && wready_o;
  assign pop      = rvalid_o && rready_i;
  assign rdata_o  = mem_q[rptr_q];
  assign depth_o  = cnt_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wptr_q <= '0;
      rptr_q <= '0;
      cnt_q  <= '0;
    end else begin
      if (push) begin
        // wrap at depth, not at a power of two
        wptr_q <= (wptr_q == PtrW'(Depth - 1)) ? '0 : wptr_q + 1'b1;
      end
      if (pop) begin
        rptr_q <= (rptr_q == PtrW'(Depth - 1)) ? '0 : rptr_q + 1'b1;
      end
      if (push && !pop) begin
        cnt_q <= cnt_q + 1'b1;
      end else if (pop && !push) begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

  // storage
  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wptr_q] <= wdata_i;
    end
  end

endmodule

//--- design/mem_rsp_if.sv
// completed-access channel between the sram controller
// and the d-channel response generator

`timescale 1ns/100ps

interface mem_rsp_if import tlul_pkg::*; ();

  // one-cycle strobe, record is valid with it
  logic     push;
  rsp_rec_t rec;
  // response fifo can take one more record
  logic     room;

  // controller side
  modport ctrl (
    output push,
    output rec,
    input  room
  );

  // response generator side
  modport gen (
    input  push,
    input  rec,
    output room
  );

endinterface

//--- design/sram_access_ctrl.sv
// a-channel acceptance and sram access sequencing
// one request in flight: put writes, get reads,
// atomics read, modify in the alu and write back

`timescale 1ns/100ps
`include "tlul_defs.svh"

module sram_access_ctrl import tlul_pkg::*; (
  input  logic                clk_i,
  input  logic                rst_ni,
  // a channel
  input  logic                a_valid_i,
  output logic                a_ready_o,
  input  logic [2:0]          a_opcode_i,
  input  logic [2:0]          a_param_i,
  input  logic [`TL_SZW-1:0]  a_size_i,
  input  logic [`TL_DBW-1:0]  a_mask_i,
  input  logic [`TL_AIW-1:0]  a_source_i,
  input  logic [`TL_AW-1:0]   a_address_i,
  input  logic [`TL_DW-1:0]   a_data_i,
  // sram port
  output logic                req_o,
  input  logic                gnt_i,
  output logic                we_o,
  output logic [`SRAM_AW-1:0] addr_o,
  output logic [`TL_DW-1:0]   wdata_o,
  output logic [`TL_DW-1:0]   wmask_o,
  input  logic [`TL_DW-1:0]   rdata_i,
  input  logic                rvalid_i,
  // [1] uncorrectable, [0] correctable and ignored here
  input  logic [1:0]          rerror_i,
  // completed accesses
  mem_rsp_if.ctrl             rsp
);

  ctrl_state_e         state_q, state_d;
  tl_a_op_e            op_q;
  logic [2:0]          param_q;
  logic [`TL_SZW-1:0]  size_q;
  logic [`TL_AIW-1:0]  source_q;
  logic [`TL_DBW-1:0]  mask_q;
  logic [`SRAM_AW-1:0] addr_q;
  logic [`TL_DW-1:0]   data_q, old_q, bit_mask, alu_result;
  logic                err_q, accept, is_put, is_atomic;

  // only take a request when idle and its response has a slot
  assign a_ready_o = (state_q == CtrlIdle) && rsp.room;
  assign accept    = a_valid_i && a_ready_o;
  assign is_put    = op_q inside {PutFullData, PutPartialData};
  assign is_atomic = op_q inside {ArithmeticData, LogicalData};

  // byte mask to bit mask
  always_comb begin
    for (int i = 0; i < `TL_DBW; i++) begin
      bit_mask[8*i +: 8] = {8{mask_q[i]}};
    end
  end

  atomic_alu u_alu (
    .arith_i  (op_q == ArithmeticData),
    .fn_i     (param_q),
    .mem_i    (old_q),
    .op_i     (data_q),
    .result_o (alu_result)
  );

  // sram request side
  assign req_o   = (state_q == CtrlAccess) || (state_q == CtrlAtomicWrite);
  assign we_o    = ((state_q == CtrlAccess) && is_put) || (state_q == CtrlAtomicWrite);
  assign addr_o  = addr_q;
  assign wmask_o = bit_mask;
  assign wdata_o = ((state_q == CtrlAtomicWrite) ? alu_result : data_q) & bit_mask;

  // push: put on its grant, get on rvalid, atomic on the write-back grant
  assign rsp.push = ((state_q == CtrlAccess) && is_put && gnt_i) ||
                    ((state_q == CtrlAtomicWait) && !is_atomic && rvalid_i) ||
                    ((state_q == CtrlAtomicWrite) && gnt_i);

  always_comb begin
    rsp.rec.d_opcode = is_put ? AccessAck : AccessAckData;
    rsp.rec.size     = size_q;
    rsp.rec.source   = source_q;
    rsp.rec.data     = '0;
    rsp.rec.error    = 1'b0;
    if (is_atomic) begin
      // atomics return the word before the update
      rsp.rec.data  = old_q & bit_mask;
      rsp.rec.error = err_q;
    end else if (!is_put) begin
      rsp.rec.data  = rdata_i & bit_mask;
      rsp.rec.error = rerror_i[1];
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      CtrlIdle:        if (accept) state_d = CtrlAccess;
      // writes finish on the grant, reads wait for data
      CtrlAccess:      if (gnt_i) state_d = is_put ? CtrlIdle : CtrlAtomicWait;
      // also serves the read wait of a get
      CtrlAtomicWait:  if (rvalid_i) state_d = is_atomic ? CtrlAtomicWrite : CtrlIdle;
      CtrlAtomicWrite: if (gnt_i) state_d = CtrlIdle;
      default:         state_d = CtrlIdle;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= CtrlIdle;
    end else begin
      state_q <= state_d;
    end
  end

  // request payload, old word and its error flag
  always_ff @(posedge clk_i) begin
    if (accept) begin
      op_q     <= tl_a_op_e'(a_opcode_i);
      param_q  <= a_param_i;
      size_q   <= a_size_i;
      source_q <= a_source_i;
      mask_q   <= a_mask_i;
      addr_q   <= a_address_i[`SRAM_AW+1:2];
      data_q   <= a_data_i;
    end
    if ((state_q == CtrlAtomicWait) && rvalid_i) begin
      old_q <= rdata_i;
      err_q <= rerror_i[1];
    end
  end

endmodule

//--- design/tlul_pkg.sv
// shared types of the tl-ul sram adapter
// a and d channel opcodes, atomic function codes,
// controller states and the response record

`include "tlul_defs.svh"

package tlul_pkg;

  // a-channel opcodes, intent hints are not supported
  typedef enum logic [2:0] {
    PutFullData    = 3'd0,
    PutPartialData = 3'd1,
    ArithmeticData = 3'd2,
    LogicalData    = 3'd3,
    Get            = 3'd4
  } tl_a_op_e;

  // d-channel opcodes
  typedef enum logic [2:0] {
    AccessAck     = 3'd0,
    AccessAckData = 3'd1
  } tl_d_op_e;

  // a_param codes for ArithmeticData
  typedef enum logic [2:0] {
    AMin  = 3'd0,
    AMax  = 3'd1,
    AMinu = 3'd2,
    AMaxu = 3'd3,
    AAdd  = 3'd4
  } arith_fn_e;

  // a_param codes for LogicalData
  typedef enum logic [2:0] {
    LXor  = 3'd0,
    LOr   = 3'd1,
    LAnd  = 3'd2,
    LSwap = 3'd3
  } logic_fn_e;

  // sram controller states
  typedef enum logic [1:0] {
    CtrlIdle,
    CtrlAccess,
    CtrlAtomicWait,
    CtrlAtomicWrite
  } ctrl_state_e;

  // one completed access, as it leaves on the d channel
  typedef struct packed {
    tl_d_op_e             d_opcode;
    logic [`TL_SZW-1:0]   size;
    logic [`TL_AIW-1:0]   source;
    logic [`TL_DW-1:0]    data;
    logic                 error;
  } rsp_rec_t;

endpackage

//--- design/tlul_rsp_gen.sv
// response fifo and d-channel driver
// records from the sram controller are queued in order
// and leave on the d channel under d_ready_i back-pressure

`timescale 1ns/100ps
`include "tlul_defs.svh"

module tlul_rsp_gen import tlul_pkg::*; (
  input  logic               clk_i,
  input  logic               rst_ni,
  // d channel
  output logic               d_valid_o,
  input  logic               d_ready_i,
  output logic [2:0]         d_opcode_o,
  output logic [`TL_SZW-1:0] d_size_o,
  output logic [`TL_AIW-1:0] d_source_o,
  output logic [`TL_DW-1:0]  d_data_o,
  output logic               d_error_o,
  // records from the controller
  mem_rsp_if.gen             rsp
);

  localparam int RecW   = $bits(rsp_rec_t);
  localparam int DepthW = $clog2(`RSP_DEPTH + 1);

  rsp_rec_t          head;
  logic [DepthW-1:0] depth;

  // wready is not watched, the controller only pushes when room was high
  fifo_sync #(
    .Width (RecW),
    .Depth (`RSP_DEPTH)
  ) u_rsp_fifo (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .wvalid_i (rsp.push),
    .wready_o (),
    .wdata_i  (rsp.rec),
    .rvalid_o (d_valid_o),
    .rready_i (d_ready_i),
    .rdata_o  (head),
    .depth_o  (depth)
  );

  // one free slot is enough for the single request in flight
  assign rsp.room = depth < DepthW'(`RSP_DEPTH);

  // fifo head is the d payload, it holds until the transfer pops it
  assign d_opcode_o = head.d_opcode;
  assign d_size_o   = head.size;
  assign d_source_o = head.source;
  assign d_data_o   = head.data;
  assign d_error_o  = head.error;

endmodule

//--- design/tlul_sram_adapter.sv
// tl-ul slave to single-port sram adapter top level
// controller and response generator joined by mem_rsp_if

`timescale 1ns/100ps
`include "tlul_defs.svh"

module tlul_sram_adapter (
  input  logic                clk_i,
  input  logic                rst_ni,
  // a channel
  input  logic                a_valid_i,
  output logic                a_ready_o,
  input  logic [2:0]          a_opcode_i,
  input  logic [2:0]          a_param_i,
  input  logic [`TL_SZW-1:0]  a_size_i,
  input  logic [`TL_DBW-1:0]  a_mask_i,
  input  logic [`TL_AIW-1:0]  a_source_i,
  input  logic [`TL_AW-1:0]   a_address_i,
  input  logic [`TL_DW-1:0]   a_data_i,
  // d channel
  output logic                d_valid_o,
  input  logic                d_ready_i,
  output logic [2:0]          d_opcode_o,
  output logic [`TL_SZW-1:0]  d_size_o,
  output logic [`TL_AIW-1:0]  d_source_o,
  output logic [`TL_DW-1:0]   d_data_o,
  output logic                d_error_o,
  // sram port
  output logic                req_o,
  input  logic                gnt_i,
  output logic                we_o,
  output logic [`SRAM_AW-1:0] addr_o,
  output logic [`TL_DW-1:0]   wdata_o,
  output logic [`TL_DW-1:0]   wmask_o,
  input  logic [`TL_DW-1:0]   rdata_i,
  input  logic                rvalid_i,
  input  logic [1:0]          rerror_i
);

  mem_rsp_if u_rsp_if ();

  sram_access_ctrl u_ctrl (
    .clk_i, .rst_ni,
    .a_valid_i, .a_ready_o, .a_opcode_i, .a_param_i, .a_size_i,
    .a_mask_i, .a_source_i, .a_address_i, .a_data_i,
    .req_o, .gnt_i, .we_o, .addr_o, .wdata_o, .wmask_o,
    .rdata_i, .rvalid_i, .rerror_i,
    .rsp (u_rsp_if.ctrl)
  );

  tlul_rsp_gen u_rsp_gen (
    .clk_i, .rst_ni,
    .d_valid_o, .d_ready_i, .d_opcode_o, .d_size_o,
    .d_source_o, .d_data_o, .d_error_o,
    .rsp (u_rsp_if.gen)
  );

endmodule

//--- include/tlul_defs.svh
// bus and memory geometry macros for the tl-ul sram adapter
// widths of the a and d channel fields, sram word address width
// and the number of response fifo entries

`ifndef TLUL_DEFS_SVH
`define TLUL_DEFS_SVH

// data word width in bits
`define TL_DW 32
// bytes per data word, one mask bit each
`define TL_DBW 4
// a-channel byte address width
`define TL_AW 32
// size field width, log2 of the byte count
`define TL_SZW 2
// source id width
`define TL_AIW 8

// sram word address width, 1024 words
`define SRAM_AW 10

// response fifo entries
`define RSP_DEPTH 2

`endif

//--- run_sim.sh
#!/usr/bin/env bash
# build the testbench with Verilator, run it and scan the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal -f sim.f --top-module tb_top -o tb_sim
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/tb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "SIMULATION FAILED" "$LOG"; then
  exit 1
fi

if ! grep -q "SIMULATION PASSED" "$LOG"; then
  echo "no result line in $LOG"
  exit 1
fi

exit 0

//--- sim.f
+incdir+include
design/tlul_pkg.sv
design/mem_rsp_if.sv
design/fifo_sync.sv
design/atomic_alu.sv
design/sram_access_ctrl.sv
design/tlul_rsp_gen.sv
design/tlul_sram_adapter.sv
tests/tb_checker.sv
tests/tb_top.sv

//--- tests/tb_checker.sv
// response checker for the tl-ul sram adapter
// shadow memory updated in acceptance order, expected-response queue,
// d-channel compare, a_ready and reset checks, directed put latency

`timescale 1ns/100ps
`include "tlul_defs.svh"

module tb_checker import tlul_pkg::*; (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                a_valid_i,
  input  logic                a_ready_i,
  input  logic [2:0]          a_opcode_i,
  input  logic [2:0]          a_param_i,
  input  logic [`TL_SZW-1:0]  a_size_i,
  input  logic [`TL_DBW-1:0]  a_mask_i,
  input  logic [`TL_AIW-1:0]  a_source_i,
  input  logic [`TL_AW-1:0]   a_address_i,
  input  logic [`TL_DW-1:0]   a_data_i,
  input  logic                d_valid_i,
  input  logic                d_ready_i,
  input  logic [2:0]          d_opcode_i,
  input  logic [`TL_SZW-1:0]  d_size_i,
  input  logic [`TL_AIW-1:0]  d_source_i,
  input  logic [`TL_DW-1:0]   d_data_i,
  input  logic                d_error_i,
  input  logic                req_i,
  input  logic                rvalid_i,
  input  logic [1:0]          rerror_i,
  input  logic                lat_chk_i,
  output int                  err_cnt_o,
  output int                  pending_o,
  output int                  resp_cnt_o
);

  localparam int MemWords = 1 << `SRAM_AW;

  logic [31:0] shadow [MemWords];
  string       exp_name [$];
  logic [2:0]  exp_op [$];
  logic [1:0]  exp_size [$];
  logic [7:0]  exp_src [$];
  logic [31:0] exp_data [$];
  logic        exp_err [$];
  logic        exp_rd [$];
  int unsigned cycle;
  int unsigned lat_start;
  logic        lat_armed;

  // same fill as the sram model
  function automatic logic [31:0] fill_word(int unsigned idx);
    return 32'hA5C3_0000 ^ (idx * 32'h0001_9E37);
  endfunction

  function automatic logic [31:0] expand_mask(logic [3:0] m);
    return {{8{m[3]}}, {8{m[2]}}, {8{m[1]}}, {8{m[0]}}};
  endfunction

  // reference atomic op, op is the request word and mem the stored word
  function automatic logic [31:0] amo_result(logic arith, logic [2:0] fn,
                                             logic [31:0] mem, logic [31:0] op);
    logic [31:0] res;
    res = mem;
    if (arith) begin
      case (fn)
        3'd0: res = ($signed(op) < $signed(mem)) ? op : mem;
        3'd1: res = ($signed(op) > $signed(mem)) ? op : mem;
        3'd2: res = (op < mem) ? op : mem;
        3'd3: res = (op > mem) ? op : mem;
        3'd4: res = op + mem;
        default: res = mem;
      endcase
    end else begin
      case (fn)
        3'd0: res = op ^ mem;
        3'd1: res = op | mem;
        3'd2: res = op & mem;
        3'd3: res = op;
        default: res = mem;
      endcase
    end
    return res;
  endfunction

  task automatic check_field(string name, string field, logic [31:0] exp, logic [31:0] act);
    if (exp !== act) begin
      $display("ERR %s %s: expected %h, actual %h", name, field, exp, act);
      err_cnt_o++;
    end
  endtask

  initial begin
    for (int i = 0; i < MemWords; i++) begin
      shadow[i] = fill_word(i);
    end
    err_cnt_o  = 0;
    pending_o  = 0;
    resp_cnt_o = 0;
    cycle      = 0;
    lat_start  = 0;
    lat_armed  = 1'b0;
  end

  always @(posedge clk_i) begin : watch
    logic [`SRAM_AW-1:0] widx;
    logic [31:0]         bm, old;
    cycle++;
    if (!rst_ni) begin
      if (req_i || d_valid_i) begin
        $display("req_o or d_valid_o high during reset");
        err_cnt_o++;
      end
    end else begin
      // read error belongs to the one read in flight, the newest entry
      if (rvalid_i && exp_rd.size() > 0 && exp_rd[exp_rd.size() - 1]) begin
        exp_err[exp_err.size() - 1] = rerror_i[1];
      end
      // put latency, d_valid seen two edges after the acceptance edge
      if (lat_armed && d_valid_i) begin
        if (cycle - lat_start != 2) begin
          $display("ERR put latency: expected %0d, actual %0d", 2, cycle - lat_start);
          err_cnt_o++;
        end
        lat_armed = 1'b0;
      end
      if (d_valid_i && d_ready_i) begin
        if (exp_op.size() == 0) begin
          $display("d-channel response with no request outstanding");
          err_cnt_o++;
        end else begin
          check_field(exp_name[0], "opcode", 32'(exp_op[0]), 32'(d_opcode_i));
          check_field(exp_name[0], "size", 32'(exp_size[0]), 32'(d_size_i));
          check_field(exp_name[0], "source", 32'(exp_src[0]), 32'(d_source_i));
          check_field(exp_name[0], "data", exp_data[0], d_data_i);
          check_field(exp_name[0], "error", 32'(exp_err[0]), 32'(d_error_i));
          void'(exp_name.pop_front());
          void'(exp_op.pop_front());
          void'(exp_size.pop_front());
          void'(exp_src.pop_front());
          void'(exp_data.pop_front());
          void'(exp_err.pop_front());
          void'(exp_rd.pop_front());
          resp_cnt_o++;
        end
      end
      // a_ready must stay low while the fifo is full or an access is busy
      if (a_ready_i && exp_op.size() >= `RSP_DEPTH) begin
        $display("a_ready_o high with %0d responses pending", exp_op.size());
        err_cnt_o++;
      end
      if (exp_op.size() > `RSP_DEPTH + 1) begin
        $display("more responses pending than the adapter can hold");
        err_cnt_o++;
      end
      if (a_valid_i && a_ready_i) begin
        widx = a_address_i[`SRAM_AW+1:2];
        bm   = expand_mask(a_mask_i);
        old  = shadow[widx];
        exp_size.push_back(a_size_i);
        exp_src.push_back(a_source_i);
        exp_err.push_back(1'b0);
        if (a_opcode_i == PutFullData || a_opcode_i == PutPartialData) begin
          exp_name.push_back("put");
          exp_op.push_back(AccessAck);
          exp_data.push_back('0);
          exp_rd.push_back(1'b0);
          shadow[widx] = (old & ~bm) | (a_data_i & bm);
        end else begin
          exp_op.push_back(AccessAckData);
          exp_data.push_back(old & bm);
          exp_rd.push_back(1'b1);
          if (a_opcode_i == Get) begin
            exp_name.push_back("get");
          end else begin
            exp_name.push_back((a_opcode_i == ArithmeticData) ? "arith" : "logic");
            // the old word is returned, the result is stored under the mask
            shadow[widx] = (old & ~bm) |
              (amo_result(a_opcode_i == ArithmeticData, a_param_i, old, a_data_i) & bm);
          end
        end
        if (lat_chk_i) begin
          lat_start = cycle;
          lat_armed = 1'b1;
        end
      end
    end
    pending_o = exp_op.size();
  end

endmodule

//--- tests/tb_top.sv
// testbench top for the tl-ul sram adapter
// clock, reset, random a-channel stimulus, sram model with random grant
// and read errors, d_ready back-pressure, watchdog, checker beside uut

`timescale 1ns/100ps
`include "tlul_defs.svh"

module tb_top import tlul_pkg::*; ();

  localparam int ClkPeriod = 20;
  localparam int NumReq    = 400;
  localparam int MemWords  = 1 << `SRAM_AW;

  logic                clk_i = 1'b0;
  logic                rst_ni;
  logic                a_valid_i, a_ready_o;
  logic [2:0]          a_opcode_i, a_param_i;
  logic [`TL_SZW-1:0]  a_size_i;
  logic [`TL_DBW-1:0]  a_mask_i;
  logic [`TL_AIW-1:0]  a_source_i;
  logic [`TL_AW-1:0]   a_address_i;
  logic [`TL_DW-1:0]   a_data_i;
  logic                d_valid_o, d_ready_i, d_error_o;
  logic [2:0]          d_opcode_o;
  logic [`TL_SZW-1:0]  d_size_o;
  logic [`TL_AIW-1:0]  d_source_o;
  logic [`TL_DW-1:0]   d_data_o;
  logic                req_o, gnt_i, we_o, rvalid_i;
  logic [`SRAM_AW-1:0] addr_o;
  logic [`TL_DW-1:0]   wdata_o, wmask_o, rdata_i;
  logic [1:0]          rerror_i;

  // sram model state
  logic [`TL_DW-1:0]   sram_mem [MemWords];
  logic                rd_pend;
  logic [`SRAM_AW-1:0] rd_addr;
  // force gnt_i and d_ready_i high for the directed latency test
  logic                force_hi;
  logic                lat_chk;
  int                  stall_left = 0;
  int                  err_cnt, pending, resp_cnt;

  always #(ClkPeriod / 2) clk_i = ~clk_i;

  // initial sram contents in which every address bit shows up
  function automatic logic [31:0] fill_word(int unsigned idx);
    return 32'hA5C3_0000 ^ (idx * 32'h0001_9E37);
  endfunction

  tlul_sram_adapter uut (.*);

  tb_checker u_chk (
    .clk_i, .rst_ni,
    .a_valid_i, .a_ready_i (a_ready_o), .a_opcode_i, .a_param_i, .a_size_i,
    .a_mask_i, .a_source_i, .a_address_i, .a_data_i,
    .d_valid_i (d_valid_o), .d_ready_i, .d_opcode_i (d_opcode_o),
    .d_size_i (d_size_o), .d_source_i (d_source_o), .d_data_i (d_data_o),
    .d_error_i (d_error_o),
    .req_i (req_o), .rvalid_i, .rerror_i,
    .lat_chk_i (lat_chk),
    .err_cnt_o (err_cnt), .pending_o (pending), .resp_cnt_o (resp_cnt)
  );

  // sram writes land on the grant edge, a granted read answers one cycle later
  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_pend <= 1'b0;
      rd_addr <= '0;
    end else begin
      if (req_o && gnt_i && we_o) begin
        sram_mem[addr_o] <= (sram_mem[addr_o] & ~wmask_o) | (wdata_o & wmask_o);
      end
      rd_pend <= req_o && gnt_i && !we_o;
      rd_addr <= addr_o;
    end
  end

  // sram outputs and d_ready change on the falling edge
  always @(negedge clk_i) begin
    gnt_i    <= force_hi ? 1'b1 : ($urandom_range(3) != 0);
    rvalid_i <= rd_pend;
    rdata_i  <= rd_pend ? sram_mem[rd_addr] : '0;
    // uncorrectable error on about one read in 16
    rerror_i <= {rd_pend && ($urandom_range(15) == 0), 1'b0};
    if (force_hi) begin
      d_ready_i <= 1'b1;
    end else if (stall_left > 0) begin
      d_ready_i  <= 1'b0;
      stall_left <= stall_left - 1;
    end else if ($urandom_range(31) == 0) begin
      // long stall so the response fifo fills up
      d_ready_i  <= 1'b0;
      stall_left <= 10 + int'($urandom_range(20));
    end else begin
      d_ready_i <= ($urandom_range(3) != 0);
    end
  end

  // hold one request until accepted, then drop a_valid_i
  // a_ready_o seen at the falling edge holds through the next rising edge
  task automatic send_req(input tl_a_op_e op, input logic [2:0] param,
                          input logic [1:0] size, input logic [3:0] mask,
                          input logic [7:0] src, input logic [31:0] addr,
                          input logic [31:0] data);
    @(negedge clk_i);
    a_valid_i   = 1'b1;
    a_opcode_i  = op;
    a_param_i   = param;
    a_size_i    = size;
    a_mask_i    = mask;
    a_source_i  = src;
    a_address_i = addr;
    a_data_i    = data;
    while (!a_ready_o) @(negedge clk_i);
    @(negedge clk_i);
    a_valid_i = 1'b0;
  endtask

  // random opcode mix over 16 words so accesses hit each other
  task automatic issue_random();
    int unsigned pick;
    tl_a_op_e    op;
    logic [2:0]  param;
    logic [3:0]  mask;
    pick  = $urandom_range(9);
    param = 3'd0;
    mask  = 4'($urandom_range(14) + 1);
    if (pick < 2) begin
      op   = PutFullData;
      mask = 4'hF;
    end else if (pick < 4) begin
      op = PutPartialData;
    end else if (pick == 7) begin
      op    = ArithmeticData;
      param = 3'($urandom_range(4));
    end else if (pick == 8) begin
      op    = LogicalData;
      param = 3'($urandom_range(3));
    end else begin
      op = Get;
    end
    send_req(op, param, 2'($urandom_range(2)), mask, 8'($urandom_range(255)),
             32'($urandom_range(15)) << 2, $urandom());
  endtask

  // watchdog allows about 60 cycles per request
  initial begin
    #(longint'(NumReq) * 60 * ClkPeriod);
    $display("timeout: responses still missing after %0d requests", NumReq);
    $display("SIMULATION FAILED");
    $finish;
  end

  initial begin
    void'($urandom(56451));
    for (int i = 0; i < MemWords; i++) begin
      sram_mem[i] = fill_word(i);
    end
    rst_ni      = 1'b0;
    a_valid_i   = 1'b0;
    a_opcode_i  = '0;
    a_param_i   = '0;
    a_size_i    = '0;
    a_mask_i    = '0;
    a_source_i  = '0;
    a_address_i = '0;
    a_data_i    = '0;
    d_ready_i   = 1'b0;
    gnt_i       = 1'b0;
    rvalid_i    = 1'b0;
    rdata_i     = '0;
    rerror_i    = '0;
    force_hi    = 1'b0;
    lat_chk     = 1'b0;
    repeat (8) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni   = 1'b1;
    // directed put with grant and d_ready held high
    force_hi = 1'b1;
    lat_chk  = 1'b1;
    send_req(PutFullData, 3'd0, 2'd2, 4'hF, 8'h5A, 32'h0000_0040, 32'hDEAD_BEEF);
    while (pending != 0) @(negedge clk_i);
    lat_chk  = 1'b0;
    force_hi = 1'b0;
    repeat (NumReq) issue_random();
    while (pending != 0) @(negedge clk_i);
    repeat (2) @(negedge clk_i);
    $display("run done: %0d responses checked, %0d errors", resp_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule
